//--- support_pkg.sv
// Support register file types, register offsets and block identity.
package support_pkg;

  localparam int N_IM_PAIRS = 9;

  typedef logic [15:0] rbus_addr_t;
  typedef logic [31:0] rbus_data_t;
  typedef logic [7:0]  locl_addr_t;

  // Bit 2k is the low bank of pair k, bit 2k+1 the high bank.
  // Pairs: lz77 comp, lz77 decomp, htf bl, xp10 comp, xp10 decomp,
  // he sh, he lng, he st sh, he st lng.
  typedef logic [2*N_IM_PAIRS-1:0] im_bank_t;

  typedef logic [15:0] ctl_t;
  typedef logic [1:0]  df_mux_sel_t;

  // Read together at offset 0x00.
  localparam logic [15:0] BLKID = 16'hcc64;
  localparam logic [15:0] REVID = 16'h0102;

  // Word offsets inside the window.
  localparam locl_addr_t REG_BLKID_REVID  = 8'h00;
  localparam locl_addr_t REG_SPARE        = 8'h01;
  localparam locl_addr_t REG_CTL          = 8'h02;
  localparam locl_addr_t REG_DF_MUX       = 8'h03;
  localparam locl_addr_t REG_PIPE_STAT    = 8'h04;
  localparam locl_addr_t REG_IM_AVAILABLE = 8'h05;
  localparam locl_addr_t REG_IM_CONSUMED  = 8'h06;
  localparam locl_addr_t REG_INT0_STATUS  = 8'h08;
  localparam locl_addr_t REG_INT0_MASK    = 8'h09;
  localparam locl_addr_t REG_INT1_STATUS  = 8'h0A;
  localparam locl_addr_t REG_INT1_MASK    = 8'h0B;

endpackage

//--- event_interrupt.sv
// Event interrupt controller with sticky status, mask and a registered interrupt line.
`timescale 1ns/1ns

module event_interrupt #(
  parameter int N_INT_BITS = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [N_INT_BITS-1:0] i_events,
  input  logic                  i_status_wr,
  input  logic                  i_mask_wr,
  input  logic [N_INT_BITS-1:0] i_wr_data,
  output logic [N_INT_BITS-1:0] o_status,
  output logic [N_INT_BITS-1:0] o_mask,
  output logic                  o_int
);

  logic [N_INT_BITS-1:0] clr_bits;
  logic [N_INT_BITS-1:0] pending;

  // Write-1-to-clear.
  assign clr_bits = i_status_wr ? i_wr_data : '0;

  // A mask bit of one hides its source.
  assign pending = o_status & ~o_mask;

  // New events take priority over a clear in the same cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_status <= '0;
    end else begin
      o_status <= (o_status & ~clr_bits) | i_events;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_mask <= '1;
    end else if (i_mask_wr) begin
      o_mask <= i_wr_data;
    end
  end

  // One cycle behind the status.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_int <= 1'b0;
    end else begin
      o_int <= |pending;
    end
  end

endmodule

//--- im_bank_tracker.sv
// Intermediate memory bank tracker: samples available flags and pulses consumed flags.
`timescale 1ns/1ns

module im_bank_tracker
  import support_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  im_bank_t i_im_available,
  input  logic     i_consumed_wr,
  input  im_bank_t i_wr_data,
  output im_bank_t o_im_available,
  output im_bank_t o_im_consumed
);

  // Flags from the banks, one cycle late.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_im_available <= '0;
    end else begin
      o_im_available <= i_im_available;
    end
  end

  // Single-cycle pulse per written bit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_im_consumed <= '0;
    end else if (i_consumed_wr) begin
      o_im_consumed <= i_wr_data;
    end else begin
      o_im_consumed <= '0;
    end
  end

endmodule

//--- support_regs.sv
// Support register block: window decode, config registers, read mux and bus response.
`timescale 1ns/1ns

module support_regs
  import support_pkg::*;
#(
  parameter int N_INT0_BITS = 24,
  parameter int N_INT1_BITS = 10
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rbus_addr_t             i_rbus_addr,
  input  logic                   i_rbus_wr_strb,
  input  rbus_data_t             i_rbus_wr_data,
  input  logic                   i_rbus_rd_strb,
  input  rbus_addr_t             i_cfg_start_addr,
  input  rbus_addr_t             i_cfg_end_addr,
  input  rbus_data_t             i_pipe_stat,
  input  im_bank_t               i_im_available,
  input  logic [N_INT0_BITS-1:0] i_int0_status,
  input  logic [N_INT0_BITS-1:0] i_int0_mask,
  input  logic [N_INT1_BITS-1:0] i_int1_status,
  input  logic [N_INT1_BITS-1:0] i_int1_mask,
  output rbus_data_t             o_rbus_rd_data,
  output logic                   o_rbus_ack,
  output logic                   o_rbus_err_ack,
  output ctl_t                   o_ctl_config,
  output df_mux_sel_t            o_df_mux_sel,
  output logic                   o_consumed_wr,
  output logic                   o_int0_status_wr,
  output logic                   o_int0_mask_wr,
  output logic                   o_int1_status_wr,
  output logic                   o_int1_mask_wr,
  output rbus_data_t             o_wr_data
);

  localparam int LOCL_W = $bits(locl_addr_t);
  localparam int ADDR_W = $bits(rbus_addr_t);

  rbus_addr_t  addr_diff;
  locl_addr_t  offset;
  logic        in_window;
  logic        mapped;
  logic        wr_hit;
  rbus_data_t  rd_value;
  rbus_data_t  spare_q;
  ctl_t        ctl_q;
  df_mux_sel_t df_mux_q;

  // Window bounds are inclusive.
  assign in_window = (i_rbus_wr_strb | i_rbus_rd_strb) &&
                     (i_rbus_addr >= i_cfg_start_addr) &&
                     (i_rbus_addr <= i_cfg_end_addr);

  assign addr_diff = i_rbus_addr - i_cfg_start_addr;
  assign offset    = addr_diff[LOCL_W-1:0];

  always_comb begin
    mapped   = 1'b1;
    rd_value = '0;
    case (offset)
      REG_BLKID_REVID:  rd_value = {BLKID, REVID};
      REG_SPARE:        rd_value = spare_q;
      REG_CTL:          rd_value = rbus_data_t'(ctl_q);
      REG_DF_MUX:       rd_value = rbus_data_t'(df_mux_q);
      REG_PIPE_STAT:    rd_value = i_pipe_stat;
      REG_IM_AVAILABLE: rd_value = rbus_data_t'(i_im_available);
      REG_IM_CONSUMED:  rd_value = '0;
      REG_INT0_STATUS:  rd_value = rbus_data_t'(i_int0_status);
      REG_INT0_MASK:    rd_value = rbus_data_t'(i_int0_mask);
      REG_INT1_STATUS:  rd_value = rbus_data_t'(i_int1_status);
      REG_INT1_MASK:    rd_value = rbus_data_t'(i_int1_mask);
      default:          mapped = 1'b0;
    endcase
    // Large windows alias nothing beyond the local map.
    if (addr_diff[ADDR_W-1:LOCL_W] != '0) begin
      mapped = 1'b0;
    end
  end

  assign wr_hit = i_rbus_wr_strb && in_window && mapped;

  // Side block strobes, same cycle as the bus strobe.
  assign o_consumed_wr    = wr_hit && (offset == REG_IM_CONSUMED);
  assign o_int0_status_wr = wr_hit && (offset == REG_INT0_STATUS);
  assign o_int0_mask_wr   = wr_hit && (offset == REG_INT0_MASK);
  assign o_int1_status_wr = wr_hit && (offset == REG_INT1_STATUS);
  assign o_int1_mask_wr   = wr_hit && (offset == REG_INT1_MASK);
  assign o_wr_data        = i_rbus_wr_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spare_q  <= '0;
      ctl_q    <= '0;
      df_mux_q <= '0;
    end else if (wr_hit) begin
      case (offset)
        REG_SPARE:  spare_q  <= i_rbus_wr_data;
        REG_CTL:    ctl_q    <= i_rbus_wr_data[$bits(ctl_t)-1:0];
        REG_DF_MUX: df_mux_q <= i_rbus_wr_data[$bits(df_mux_sel_t)-1:0];
        default:    ;
      endcase
    end
  end

  assign o_ctl_config = ctl_q;
  assign o_df_mux_sel = df_mux_q;

  // Response one cycle after the strobe.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rbus_ack     <= 1'b0;
      o_rbus_err_ack <= 1'b0;
      o_rbus_rd_data <= '0;
    end else begin
      o_rbus_ack     <= in_window && mapped;
      o_rbus_err_ack <= in_window && !mapped;
      if (i_rbus_rd_strb && in_window && mapped) begin
        o_rbus_rd_data <= rd_value;
      end
    end
  end

endmodule

//--- cceip_support_top.sv
// Compression engine support block top: register block, bank tracker and two interrupt controllers.
`timescale 1ns/1ns

module cceip_support_top
  import support_pkg::*;
#(
  parameter int N_INT0_BITS = 24,
  parameter int N_INT1_BITS = 10
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rbus_addr_t             i_rbus_addr,
  input  logic                   i_rbus_wr_strb,
  input  rbus_data_t             i_rbus_wr_data,
  input  logic                   i_rbus_rd_strb,
  input  rbus_addr_t             i_cfg_start_addr,
  input  rbus_addr_t             i_cfg_end_addr,
  input  rbus_data_t             i_pipe_stat,
  input  im_bank_t               i_im_available,
  input  logic [N_INT0_BITS-1:0] i_int0_events,
  input  logic [N_INT1_BITS-1:0] i_int1_events,
  output rbus_data_t             o_rbus_rd_data,
  output logic                   o_rbus_ack,
  output logic                   o_rbus_err_ack,
  output im_bank_t               o_im_consumed,
  output ctl_t                   o_ctl_config,
  output df_mux_sel_t            o_df_mux_sel,
  output logic                   o_int0,
  output logic                   o_int1
);

  im_bank_t               im_available_q;
  logic                   consumed_wr;
  logic                   int0_status_wr;
  logic                   int0_mask_wr;
  logic                   int1_status_wr;
  logic                   int1_mask_wr;
  rbus_data_t             wr_data;
  logic [N_INT0_BITS-1:0] int0_status;
  logic [N_INT0_BITS-1:0] int0_mask;
  logic [N_INT1_BITS-1:0] int1_status;
  logic [N_INT1_BITS-1:0] int1_mask;

  support_regs #(
    .N_INT0_BITS (N_INT0_BITS),
    .N_INT1_BITS (N_INT1_BITS)
  ) u_regs (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_rbus_addr      (i_rbus_addr),
    .i_rbus_wr_strb   (i_rbus_wr_strb),
    .i_rbus_wr_data   (i_rbus_wr_data),
    .i_rbus_rd_strb   (i_rbus_rd_strb),
    .i_cfg_start_addr (i_cfg_start_addr),
    .i_cfg_end_addr   (i_cfg_end_addr),
    .i_pipe_stat      (i_pipe_stat),
    .i_im_available   (im_available_q),
    .i_int0_status    (int0_status),
    .i_int0_mask      (int0_mask),
    .i_int1_status    (int1_status),
    .i_int1_mask      (int1_mask),
    .o_rbus_rd_data   (o_rbus_rd_data),
    .o_rbus_ack       (o_rbus_ack),
    .o_rbus_err_ack   (o_rbus_err_ack),
    .o_ctl_config     (o_ctl_config),
    .o_df_mux_sel     (o_df_mux_sel),
    .o_consumed_wr    (consumed_wr),
    .o_int0_status_wr (int0_status_wr),
    .o_int0_mask_wr   (int0_mask_wr),
    .o_int1_status_wr (int1_status_wr),
    .o_int1_mask_wr   (int1_mask_wr),
    .o_wr_data        (wr_data)
  );

  im_bank_tracker u_bank (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_im_available (i_im_available),
    .i_consumed_wr  (consumed_wr),
    .i_wr_data      (wr_data[$bits(im_bank_t)-1:0]),
    .o_im_available (im_available_q),
    .o_im_consumed  (o_im_consumed)
  );

  // Bit 23 is an ordinary external source.
  event_interrupt #(
    .N_INT_BITS (N_INT0_BITS)
  ) u_int0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_events    (i_int0_events),
    .i_status_wr (int0_status_wr),
    .i_mask_wr   (int0_mask_wr),
    .i_wr_data   (wr_data[N_INT0_BITS-1:0]),
    .o_status    (int0_status),
    .o_mask      (int0_mask),
    .o_int       (o_int0)
  );

  event_interrupt #(
    .N_INT_BITS (N_INT1_BITS)
  ) u_int1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_events    (i_int1_events),
    .i_status_wr (int1_status_wr),
    .i_mask_wr   (int1_mask_wr),
    .i_wr_data   (wr_data[N_INT1_BITS-1:0]),
    .o_status    (int1_status),
    .o_mask      (int1_mask),
    .o_int       (o_int1)
  );

endmodule

//--- cceip_support_properties.sv
// Bus response and interrupt properties for the support block.
`timescale 1ns/1ns

module cceip_support_properties #(
  parameter int N_INT_BITS = 1,
  parameter bit BUS_SIDE   = 1'b0
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  i_strb,
  input logic                  i_ack,
  input logic                  i_err_ack,
  input logic [N_INT_BITS-1:0] i_status,
  input logic [N_INT_BITS-1:0] i_mask,
  input logic                  i_int
);

  if (BUS_SIDE) begin : g_bus

    ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(i_ack && i_err_ack))
      else $error("ack and err_ack high in the same cycle");

    // Any response needs a strobe one cycle earlier.
    response_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      (i_ack || i_err_ack) |-> $past(i_strb))
      else $error("bus response without a strobe in the cycle before");

  end else begin : g_int

    masked_int_low: assert property (@(posedge clk) disable iff (!rst_n)
      ((i_status & ~i_mask) == '0) |=> !i_int)
      else $error("interrupt raised while every status bit was masked");

  end

endmodule

bind support_regs cceip_support_properties #(
  .N_INT_BITS (1),
  .BUS_SIDE   (1'b1)
) u_bus_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .i_strb    (i_rbus_wr_strb | i_rbus_rd_strb),
  .i_ack     (o_rbus_ack),
  .i_err_ack (o_rbus_err_ack),
  .i_status  (1'b0),
  .i_mask    (1'b1),
  .i_int     (1'b0)
);

bind event_interrupt cceip_support_properties #(
  .N_INT_BITS (N_INT_BITS),
  .BUS_SIDE   (1'b0)
) u_int_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .i_strb    (1'b0),
  .i_ack     (1'b0),
  .i_err_ack (1'b0),
  .i_status  (o_status),
  .i_mask    (o_mask),
  .i_int     (o_int)
);

//--- tb_cceip_support.sv
// Testbench for the support block: runs the test data table and checks bus, banks and interrupts.
`timescale 1ns/1ns

module tb_cceip_support
  import support_pkg::*;
();

  localparam int         N_INT0     = 24;
  localparam int         N_INT1     = 10;
  localparam int         MAX_LINES  = 64;
  localparam rbus_addr_t START_ADDR = 16'h0400;
  localparam rbus_addr_t END_ADDR   = 16'h04ff;

  logic              clk;
  logic              rst_n;
  rbus_addr_t        rbus_addr;
  logic              rbus_wr_strb;
  rbus_data_t        rbus_wr_data;
  logic              rbus_rd_strb;
  rbus_data_t        pipe_stat;
  im_bank_t          im_available;
  logic [N_INT0-1:0] int0_events;
  logic [N_INT1-1:0] int1_events;
  rbus_data_t        rbus_rd_data;
  logic              rbus_ack;
  logic              rbus_err_ack;
  im_bank_t          im_consumed;
  ctl_t              ctl_config;
  df_mux_sel_t       df_mux_sel;
  logic              int0;
  logic              int1;

  // Three words per line: opcode, address or value, expected data.
  logic [31:0] td [0:3*MAX_LINES-1];
  int          n_lines;
  int          data_errors;
  int          bank_errors;
  int          bit_errors;
  int          other_errors;
  integer      seed;

  cceip_support_top #(
    .N_INT0_BITS (N_INT0),
    .N_INT1_BITS (N_INT1)
  ) dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_rbus_addr      (rbus_addr),
    .i_rbus_wr_strb   (rbus_wr_strb),
    .i_rbus_wr_data   (rbus_wr_data),
    .i_rbus_rd_strb   (rbus_rd_strb),
    .i_cfg_start_addr (START_ADDR),
    .i_cfg_end_addr   (END_ADDR),
    .i_pipe_stat      (pipe_stat),
    .i_im_available   (im_available),
    .i_int0_events    (int0_events),
    .i_int1_events    (int1_events),
    .o_rbus_rd_data   (rbus_rd_data),
    .o_rbus_ack       (rbus_ack),
    .o_rbus_err_ack   (rbus_err_ack),
    .o_im_consumed    (im_consumed),
    .o_ctl_config     (ctl_config),
    .o_df_mux_sel     (df_mux_sel),
    .o_int0           (int0),
    .o_int1           (int1)
  );

  always #2 clk = ~clk;

  task automatic check_data(input rbus_data_t got, input rbus_data_t exp, input string what);
    if (got !== exp) begin
      data_errors++;
      $display("mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_bank(input im_bank_t got, input im_bank_t exp, input string what);
    if (got !== exp) begin
      bank_errors++;
      $display("mismatch at %0t: %s got %05h expected %05h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bit_errors++;
      $display("mismatch at %0t: %s got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic expect_ack(input logic ack, input logic err, input string what);
    if (!ack || err) begin
      other_errors++;
      $display("%0t: no ack for %s (err_ack was %0b)", $time, what, err);
    end
  endtask

  // One strobe, then up to four cycles for the response.
  task automatic bus_access(input logic is_wr, input rbus_addr_t addr, input rbus_data_t data,
                            output logic ack, output logic err, output rbus_data_t rdata);
    int n;
    @(posedge clk);
    #1;
    rbus_addr    = addr;
    rbus_wr_data = data;
    rbus_wr_strb = is_wr;
    rbus_rd_strb = !is_wr;
    @(posedge clk);
    #1;
    rbus_wr_strb = 1'b0;
    rbus_rd_strb = 1'b0;
    n = 0;
    while (!rbus_ack && !rbus_err_ack && n < 4) begin
      @(posedge clk);
      #1;
      n++;
    end
    ack   = rbus_ack;
    err   = rbus_err_ack;
    rdata = rbus_rd_data;
  endtask

  initial begin : main_seq
    logic              ack;
    logic              err;
    rbus_data_t        rdata;
    logic [31:0]       op;
    logic [31:0]       arg;
    logic [31:0]       val;
    logic [31:0]       rnd;
    logic [N_INT1-1:0] model;
    clk          = 1'b0;
    rst_n        = 1'b0;
    rbus_addr    = '0;
    rbus_wr_strb = 1'b0;
    rbus_wr_data = '0;
    rbus_rd_strb = 1'b0;
    pipe_stat    = 32'h5eed0bad;
    im_available = '0;
    int0_events  = '0;
    int1_events  = '0;
    seed         = 32'h6aa1;
    $readmemh("cceip_support_testdata.txt", td);
    n_lines = 0;
    while (n_lines < MAX_LINES && td[3*n_lines] != 32'h0) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      other_errors++;
      $display("test data file is missing or holds no operations");
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      op  = td[3*i];
      arg = td[3*i+1];
      val = td[3*i+2];
      case (op)
        1: begin
          bus_access(1'b1, START_ADDR + arg[15:0], val, ack, err, rdata);
          expect_ack(ack, err, $sformatf("write to offset %02h", arg[7:0]));
          if (locl_addr_t'(arg) == REG_CTL) begin
            check_data(rbus_data_t'(ctl_config), val & 32'hffff, "control output");
          end
          if (locl_addr_t'(arg) == REG_DF_MUX) begin
            check_data(rbus_data_t'(df_mux_sel), val & 32'h3, "mux select output");
          end
        end
        2: begin
          bus_access(1'b0, START_ADDR + arg[15:0], '0, ack, err, rdata);
          expect_ack(ack, err, $sformatf("read of offset %02h", arg[7:0]));
          check_data(rdata, val, $sformatf("read of offset %02h", arg[7:0]));
        end
        3: begin
          bus_access(1'b1, START_ADDR + arg[15:0], val, ack, err, rdata);
          if (!err || ack) begin
            other_errors++;
            $display("%0t: offset %02h was not answered with err_ack", $time, arg[7:0]);
          end
        end
        4: begin
          @(posedge clk);
          #1;
          if (arg[0]) begin
            int1_events = val[N_INT1-1:0];
          end else begin
            int0_events = val[N_INT0-1:0];
          end
          @(posedge clk);
          #1;
          int0_events = '0;
          int1_events = '0;
        end
        5: begin
          @(posedge clk);
          #1;
          im_available = im_bank_t'(val);
        end
        6: begin
          bus_access(1'b1, START_ADDR + REG_IM_CONSUMED, val, ack, err, rdata);
          expect_ack(ack, err, "write to the consumed register");
          check_bank(im_consumed, im_bank_t'(val), "consumed pulse");
          @(posedge clk);
          #1;
          check_bank(im_consumed, '0, "consumed after the pulse");
        end
        7: begin
          repeat (2) @(posedge clk);
          #1;
          check_bit(arg[0] ? int1 : int0, val[0], $sformatf("interrupt line %0d", arg[0]));
        end
        8: begin
          bus_access(1'b0, arg[15:0], '0, ack, err, rdata);
          if (ack || err) begin
            other_errors++;
            $display("%0t: address %04h outside the window got a response", $time, arg[15:0]);
          end
        end
        9: begin
          // Sparse random events against a sticky OR model.
          model = '0;
          repeat (arg) begin
            @(posedge clk);
            #1;
            rnd         = $random(seed);
            int1_events = rnd[9:0] & rnd[19:10];
            model       = model | int1_events;
          end
          @(posedge clk);
          #1;
          int1_events = '0;
          bus_access(1'b0, START_ADDR + REG_INT1_STATUS, '0, ack, err, rdata);
          expect_ack(ack, err, "read of int1 status");
          check_data(rdata, rbus_data_t'(model), "int1 sticky status");
        end
        default: begin
          other_errors++;
          $display("unknown opcode %0h on test data line %0d", op, i);
        end
      endcase
    end
    $display("errors: data %0d bank %0d bit %0d other %0d",
             data_errors, bank_errors, bit_errors, other_errors);
    if (data_errors + bank_errors + bit_errors + other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Budget of 20 cycles per line plus reset.
  initial begin : watchdog
    int budget;
    #1;
    budget = (n_lines + 1) * 20 * 4;
    #(budget);
    $display("timeout: test data did not finish within %0d ns", budget);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- cceip_support_testdata.txt
// op, arg, value. op 1 write, 2 read, 3 err write, 4 events (arg 0/1 = int0/int1),
// 5 available flags, 6 consumed write, 7 expect int (arg 0/1), 8 outside, 9 random int1, 0 end
2 00 cc640102
2 01 00000000
2 09 00ffffff
2 0b 000003ff
2 04 5eed0bad
1 01 a5a55a5a
2 01 a5a55a5a
1 02 0001beef
2 02 0000beef
1 03 00000006
2 03 00000002
1 00 12345678
2 00 cc640102
3 07 ffffffff
3 20 00000001
2 01 a5a55a5a
8 0500 00000000
8 03ff 00000000
5 00 0002a5c3
2 05 0002a5c3
6 00 00030081
6 00 00000010
2 06 00000000
4 00 00800005
2 08 00800005
7 00 00000000
1 09 00fffffe
7 00 00000001
1 08 00000001
7 00 00000000
2 08 00800004
1 0b 000003fd
4 01 00000002
2 0a 00000002
7 01 00000001
1 0a 00000002
7 01 00000000
2 0a 00000000
9 0a 00000000
0 00 00000000

//--- cceip_support_top.f
support_pkg.sv
event_interrupt.sv
im_bank_tracker.sv
support_regs.sv
cceip_support_top.sv
cceip_support_properties.sv
tb_cceip_support.sv

//--- Makefile
TOP = tb_cceip_support

all: run

compile:
	verilator --binary --assert -f cceip_support_top.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
